/* files.f */
+incdir+.
md_pkg.sv
md_dispatch.sv
radix4_divider.sv
radix4_multiplier.sv
wb_arbiter.sv
md_unit.sv
md_checker.sv
tb_md_unit.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the md_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vtb_md_unit

verilator --binary --timing --assert -f files.f --top-module tb_md_unit -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator compile step returned an error"
	exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "sim failed" "$LOG"; then
	exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
	echo "No pass line found in $LOG"
	exit 1
fi
exit 0

/* tb_md_unit.sv */
`timescale 1ns/1ps
`include "md_defs.svh"

module tb_md_unit;
	localparam int N_DIR          = 30;
	localparam int N_RAND         = 40;
	localparam int N_TOTAL        = N_DIR + N_RAND;
	localparam int TIMEOUT_CYCLES = N_TOTAL * 40 + 200;

	typedef struct packed {
		md_pkg::md_op_e       op;
		logic [`MD_WIDTH-1:0] a;
		logic [`MD_WIDTH-1:0] b;
		logic [3:0]           gap;
	} stim_t;

	logic               CLK, nRST, issue;
	logic               mul_busy, div_busy, wb_valid;
	md_pkg::md_req_t    req;
	md_pkg::md_result_t wb;
	int                 error_count, issued, written, outstanding;
	int                 cycle_count;
	integer             seed;
	stim_t              entries [0:N_TOTAL-1];

	// Divides alternate with multiplies so both units overlap
	stim_t directed [0:N_DIR-1] = '{
		'{md_pkg::OP_DIVU,   32'd100,        32'd7,          4'd0},
		'{md_pkg::OP_MUL,    32'hffff_ffff,  32'hffff_ffff,  4'd0},
		'{md_pkg::OP_REMU,   32'd100,        32'd7,          4'd0},
		'{md_pkg::OP_MULH,   32'hffff_ffff,  32'hffff_ffff,  4'd0},
		'{md_pkg::OP_DIVU,   32'd5,          32'd9,          4'd0},
		'{md_pkg::OP_MULHSU, 32'hffff_ffff,  32'hffff_ffff,  4'd0},
		'{md_pkg::OP_REMU,   32'd5,          32'd9,          4'd0},
		'{md_pkg::OP_MULHU,  32'hffff_ffff,  32'hffff_ffff,  4'd0},
		'{md_pkg::OP_DIVU,   32'hffff_ffff,  32'd1,          4'd0},
		'{md_pkg::OP_MULH,   32'h8000_0000,  32'h8000_0000,  4'd0},
		'{md_pkg::OP_REMU,   32'hffff_ffff,  32'd10,         4'd0},
		'{md_pkg::OP_MULHSU, 32'h8000_0000,  32'hffff_ffff,  4'd0},
		'{md_pkg::OP_DIV,    32'd100,        32'd7,          4'd0},
		'{md_pkg::OP_MULHU,  32'h1234_5678,  32'h9abc_def0,  4'd0},
		'{md_pkg::OP_DIV,    32'hffff_ff9c,  32'd7,          4'd0},
		'{md_pkg::OP_MUL,    32'h7fff_ffff,  32'h8000_0000,  4'd0},
		'{md_pkg::OP_DIV,    32'd100,        32'hffff_fff9,  4'd0},
		'{md_pkg::OP_MULH,   32'h7fff_ffff,  32'h8000_0000,  4'd0},
		'{md_pkg::OP_DIV,    32'hffff_ff9c,  32'hffff_fff9,  4'd0},
		'{md_pkg::OP_MUL,    32'h1234_5678,  32'h9abc_def0,  4'd2},
		'{md_pkg::OP_REM,    32'd100,        32'd7,          4'd0},
		'{md_pkg::OP_REM,    32'hffff_ff9c,  32'd7,          4'd0},
		'{md_pkg::OP_REM,    32'd100,        32'hffff_fff9,  4'd0},
		'{md_pkg::OP_REM,    32'hffff_ff9c,  32'hffff_fff9,  4'd1},
		'{md_pkg::OP_DIV,    32'h1234_5678,  32'd0,          4'd0},
		'{md_pkg::OP_DIVU,   32'h1234_5678,  32'd0,          4'd0},
		'{md_pkg::OP_REM,    32'h8765_4321,  32'd0,          4'd0},
		'{md_pkg::OP_REMU,   32'h8765_4321,  32'd0,          4'd0},
		'{md_pkg::OP_DIV,    32'h8000_0000,  32'hffff_ffff,  4'd0},
		'{md_pkg::OP_REM,    32'h8000_0000,  32'hffff_ffff,  4'd0}
	};

	md_unit md_unit_inst (
		.CLK(CLK), .nRST(nRST), .issue(issue), .req(req),
		.mul_busy(mul_busy), .div_busy(div_busy), .wb_valid(wb_valid), .wb(wb)
	);

	md_checker checker_inst (
		.CLK(CLK), .nRST(nRST), .issue(issue), .req(req),
		.mul_busy(mul_busy), .div_busy(div_busy), .wb_valid(wb_valid), .wb(wb),
		.error_count(error_count), .issued(issued), .written(written),
		.outstanding(outstanding)
	);

	always #4 CLK = ~CLK;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic build_table;
		logic [31:0] r1, r2, r3;
		for (int i = 0; i < N_DIR; i++)
			entries[i] = directed[i];
		for (int i = N_DIR; i < N_TOTAL; i++) begin
			r1 = $random(seed);
			r2 = $random(seed);
			r3 = $random(seed);
			entries[i].op  = md_pkg::md_op_e'(r1[2:0]);
			entries[i].a   = r2;
			entries[i].b   = r3;
			entries[i].gap = {2'b00, r1[9:8]};
			// Steer some operands onto the corner values
			case (r1[6:4])
				3'd0: entries[i].b = '0;
				3'd1: entries[i].b = '1;
				3'd2: entries[i].a = 32'h8000_0000;
				default: ;
			endcase
		end
	endtask

	task automatic issue_entry(input stim_t e, input int idx);
		logic        to_div;
		logic [31:0] idx_bits;
		to_div = e.op inside {md_pkg::OP_DIV, md_pkg::OP_DIVU,
			md_pkg::OP_REM, md_pkg::OP_REMU};
		idx_bits = idx;
		while (to_div ? div_busy : mul_busy)
			@(negedge CLK);
		issue   = 1'b1;
		req.op  = e.op;
		req.tag = idx_bits[`MD_TAG_BITS-1:0];
		req.a   = e.a;
		req.b   = e.b;
		@(negedge CLK);
		issue = 1'b0;
		repeat (e.gap) @(negedge CLK);
	endtask

	task automatic print_counts;
		$display("issued %0d, written back %0d, errors %0d", issued, written, error_count);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge CLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles with %0d results still outstanding",
				cycle_count, outstanding);
			print_counts();
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		CLK         = 1'b0;
		nRST        = 1'b0;
		issue       = 1'b0;
		req         = '0;
		cycle_count = 0;
		seed        = 58612;
		build_table();
		repeat (10) @(negedge CLK);
		nRST = 1'b1;
		@(negedge CLK);
		for (int i = 0; i < N_TOTAL; i++)
			issue_entry(entries[i], i);
		while (outstanding != 0)
			@(negedge CLK);
		repeat (4) @(negedge CLK);
		if (written != N_TOTAL)
			$display("Expected %0d writebacks but saw %0d", N_TOTAL, written);
		print_counts();
		if (error_count == 0 && written == N_TOTAL) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* md_checker.sv */
`timescale 1ns/1ps
`include "md_defs.svh"

module md_checker (
	input  logic               CLK,
	input  logic               nRST,
	input  logic               issue,
	input  md_pkg::md_req_t    req,
	input  logic               mul_busy,
	input  logic               div_busy,
	input  logic               wb_valid,
	input  md_pkg::md_result_t wb,
	output int                 error_count,
	output int                 issued,
	output int                 written,
	output int                 outstanding
);
	localparam int W       = `MD_WIDTH;
	localparam int NTAGS   = 1 << `MD_TAG_BITS;
	// Issue edge to the edge that samples wb_valid is 19, or 20 after a lost grant
	localparam int MAX_AGE = `MD_ITER + 4;

	logic [W-1:0] expected [NTAGS];
	logic         pending [NTAGS];
	logic         late [NTAGS];
	logic         on_div [NTAGS];
	int           issue_edge [NTAGS];
	int           edge_count;
	logic         mul_out, div_out;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// RV32M results from the full 64-bit product and 64-bit signed division
	function automatic logic [W-1:0] reference_result(md_pkg::md_op_e op,
		logic [W-1:0] a, logic [W-1:0] b);
		logic [2*W-1:0] prod_ss, prod_su, prod_uu;
		longint         sa, sb, q;
		logic [W-1:0]   r;
		prod_ss = {{W{a[W-1]}}, a} * {{W{b[W-1]}}, b};
		prod_su = {{W{a[W-1]}}, a} * {{W{1'b0}}, b};
		prod_uu = {{W{1'b0}}, a} * {{W{1'b0}}, b};
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		q  = 0;
		r  = '0;
		case (op)
			md_pkg::OP_MUL:    r = prod_uu[W-1:0];
			md_pkg::OP_MULH:   r = prod_ss[2*W-1:W];
			md_pkg::OP_MULHSU: r = prod_su[2*W-1:W];
			md_pkg::OP_MULHU:  r = prod_uu[2*W-1:W];
			md_pkg::OP_DIV: begin
				if (b == '0)
					r = '1;
				else if (a == {1'b1, {(W-1){1'b0}}} && b == '1)
					r = a;
				else begin
					q = sa / sb;
					r = q[W-1:0];
				end
			end
			md_pkg::OP_DIVU:   r = (b == '0) ? '1 : a / b;
			md_pkg::OP_REM: begin
				if (b == '0)
					r = a;
				else if (a == {1'b1, {(W-1){1'b0}}} && b == '1)
					r = '0;
				else begin
					q = sa % sb;
					r = q[W-1:0];
				end
			end
			default:           r = (b == '0) ? a : a % b;
		endcase
		return r;
	endfunction

	task automatic check_busy_levels;
		if (mul_busy !== mul_out) begin
			$display("ERR %0t mul_busy expected %b actual %b", $time, mul_out, mul_busy);
			error_count = error_count + 1;
		end
		if (div_busy !== div_out) begin
			$display("ERR %0t div_busy expected %b actual %b", $time, div_out, div_busy);
			error_count = error_count + 1;
		end
	endtask

	task automatic check_writeback;
		int t;
		t = int'(wb.tag);
		written = written + 1;
		if (outstanding == 0) begin
			$display("%0t: wb_valid with no operation outstanding (tag %0d)", $time, t);
			error_count = error_count + 1;
		end else if (!pending[t]) begin
			$display("%0t: writeback carries tag %0d, which has nothing outstanding",
				$time, t);
			error_count = error_count + 1;
		end else begin
			if (wb.value !== expected[t]) begin
				$display("ERR %0t wb.value expected %h actual %h (tag %0d)",
					$time, expected[t], wb.value, t);
				error_count = error_count + 1;
			end
			pending[t]  = 1'b0;
			late[t]     = 1'b0;
			outstanding = outstanding - 1;
			if (on_div[t])
				div_out = 1'b0;
			else
				mul_out = 1'b0;
		end
	endtask

	task automatic check_ages;
		for (int i = 0; i < NTAGS; i++) begin
			if (pending[i] && !late[i] && edge_count - issue_edge[i] >= MAX_AGE) begin
				$display("%0t: no writeback for tag %0d within %0d cycles of its issue",
					$time, i, MAX_AGE);
				late[i]     = 1'b1;
				error_count = error_count + 1;
			end
		end
	endtask

	task automatic record_issue;
		int   t;
		logic to_div;
		t      = int'(req.tag);
		to_div = req.op inside {md_pkg::OP_DIV, md_pkg::OP_DIVU,
			md_pkg::OP_REM, md_pkg::OP_REMU};
		if (pending[t]) begin
			$display("%0t: tag %0d issued again before its writeback", $time, t);
			error_count = error_count + 1;
		end else begin
			expected[t]   = reference_result(req.op, req.a, req.b);
			pending[t]    = 1'b1;
			late[t]       = 1'b0;
			on_div[t]     = to_div;
			issue_edge[t] = edge_count;
			outstanding   = outstanding + 1;
			issued        = issued + 1;
			if (to_div)
				div_out = 1'b1;
			else
				mul_out = 1'b1;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Busy levels are compared against the flags from before this edge
	always @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < NTAGS; i++) begin
				pending[i] = 1'b0;
				late[i]    = 1'b0;
				on_div[i]  = 1'b0;
			end
			mul_out     = 1'b0;
			div_out     = 1'b0;
			edge_count  = 0;
			outstanding = 0;
		end else begin
			edge_count = edge_count + 1;
			check_busy_levels();
			if (wb_valid)
				check_writeback();
			check_ages();
			if (issue)
				record_issue();
		end
	end

endmodule

/* md_unit.sv */
`timescale 1ns/1ps

module md_unit (
	input  logic               CLK,
	input  logic               nRST,
	input  logic               issue,
	input  md_pkg::md_req_t    req,
	output logic               mul_busy,
	output logic               div_busy,
	output logic               wb_valid,
	output md_pkg::md_result_t wb
);
	logic               mul_start, div_start;
	logic               mul_taken, div_taken;
	logic               mul_finished, div_finished;
	md_pkg::md_req_t    unit_req;
	md_pkg::md_result_t mul_result, div_result;

	md_dispatch dispatch_inst (
		.CLK(CLK), .nRST(nRST), .issue(issue), .req(req),
		.mul_start(mul_start), .div_start(div_start), .unit_req(unit_req),
		.mul_taken(mul_taken), .div_taken(div_taken),
		.mul_busy(mul_busy), .div_busy(div_busy)
	);

	radix4_multiplier mul_inst (
		.CLK(CLK), .nRST(nRST), .start(mul_start), .req(unit_req),
		.taken(mul_taken), .finished(mul_finished), .result(mul_result)
	);

	radix4_divider div_inst (
		.CLK(CLK), .nRST(nRST), .start(div_start), .req(unit_req),
		.taken(div_taken), .finished(div_finished), .result(div_result)
	);

	wb_arbiter arbiter_inst (
		.CLK(CLK), .nRST(nRST),
		.mul_finished(mul_finished), .mul_result(mul_result),
		.div_finished(div_finished), .div_result(div_result),
		.mul_taken(mul_taken), .div_taken(div_taken),
		.wb_valid(wb_valid), .wb(wb)
	);

endmodule

/* wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter (
	input  logic               CLK,
	input  logic               nRST,
	input  logic               mul_finished,
	input  md_pkg::md_result_t mul_result,
	input  logic               div_finished,
	input  md_pkg::md_result_t div_result,
	output logic               mul_taken,
	output logic               div_taken,
	output logic               wb_valid,
	output md_pkg::md_result_t wb
);
	logic mul_elig, div_elig;
	logic grant_any, grant_div;
	logic last_div;

	// A unit still shows finished in the cycle its taken is high
	assign mul_elig = mul_finished & ~mul_taken;
	assign div_elig = div_finished & ~div_taken;

	// On a tie the unit not granted last time wins
	assign grant_any = mul_elig | div_elig;
	assign grant_div = div_elig & (~mul_elig | ~last_div);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wb_valid  <= 1'b0;
			mul_taken <= 1'b0;
			div_taken <= 1'b0;
			last_div  <= 1'b0;
		end else begin
			wb_valid  <= grant_any;
			div_taken <= grant_div;
			mul_taken <= grant_any & ~grant_div;
			if (grant_any)
				last_div <= grant_div;
		end
	end

	// Bus payload
	always_ff @(posedge CLK) begin
		if (grant_any) begin
			if (grant_div)
				wb <= div_result;
			else
				wb <= mul_result;
		end
	end

	// A unit holds its result until it sees its taken pulse
	a_mul_taken_finished: assert property (@(posedge CLK) disable iff (!nRST)
		mul_taken |-> mul_finished);

	a_div_taken_finished: assert property (@(posedge CLK) disable iff (!nRST)
		div_taken |-> div_finished);

endmodule

/* radix4_multiplier.sv */
`timescale 1ns/1ps
`include "md_defs.svh"

module radix4_multiplier (
	input  logic               CLK,
	input  logic               nRST,
	input  logic               start,
	input  md_pkg::md_req_t    req,
	input  logic               taken,
	output logic               finished,
	output md_pkg::md_result_t result
);
	localparam int W  = `MD_WIDTH;
	localparam int CW = $clog2(`MD_ITER + 1);

	md_pkg::md_unit_e        state;
	md_pkg::md_op_e          op;
	logic [`MD_TAG_BITS-1:0] tag;
	logic [CW-1:0]           count;
	logic                    a_signed, b_signed;
	logic [W:0]              a_ext, b_ext;
	logic [2*W+1:0]          acc, mcand, mcand_x3, addend, product;
	logic [W-1:0]            mplier;
	logic                    neg_mplier;

	assign a_signed = (req.op == md_pkg::OP_MULH) || (req.op == md_pkg::OP_MULHSU);
	assign b_signed = (req.op == md_pkg::OP_MULH);
	assign a_ext    = {a_signed & req.a[W-1], req.a};
	assign b_ext    = {b_signed & req.b[W-1], req.b};
	assign finished = (state == md_pkg::HOLD);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Multiplicand moves left two places per step, so the low multiplier pair
	// always picks 0, 1, 2 or 3 times the current weight
	assign mcand_x3 = (mcand << 1) + mcand;

	always_comb begin
		case (mplier[1:0])
			2'd0: addend = '0;
			2'd1: addend = mcand;
			2'd2: addend = mcand << 1;
			default: addend = mcand_x3;
		endcase
	end

	// After the last step mcand is the multiplicand at weight 2^W, which is
	// exactly the term a negative 33-bit multiplier owes
	assign product = neg_mplier ? (acc - mcand) : acc;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= md_pkg::IDLE;
			count <= '0;
		end else begin
			case (state)
				md_pkg::IDLE: begin
					if (start) begin
						state <= md_pkg::RUN;
						count <= CW'(`MD_ITER);
					end
				end
				md_pkg::RUN: begin
					count <= count - 1'b1;
					if (count == CW'(1))
						state <= md_pkg::DONE;
				end
				md_pkg::DONE: state <= md_pkg::HOLD;
				md_pkg::HOLD: begin
					if (taken)
						state <= md_pkg::IDLE;
				end
				default: state <= md_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == md_pkg::IDLE && start) begin
			op         <= req.op;
			tag        <= req.tag;
			mcand      <= {{(W+1){a_ext[W]}}, a_ext};
			mplier     <= b_ext[W-1:0];
			neg_mplier <= b_ext[W];
			acc        <= '0;
		end else if (state == md_pkg::RUN) begin
			acc    <= acc + addend;
			mcand  <= mcand << 2;
			mplier <= mplier >> 2;
		end else if (state == md_pkg::DONE) begin
			result.tag <= tag;
			if (op == md_pkg::OP_MUL)
				result.value <= product[W-1:0];
			else
				result.value <= product[2*W-1:W];
		end
	end

endmodule

/* radix4_divider.sv */
`timescale 1ns/1ps
`include "md_defs.svh"

module radix4_divider (
	input  logic               CLK,
	input  logic               nRST,
	input  logic               start,
	input  md_pkg::md_req_t    req,
	input  logic               taken,
	output logic               finished,
	output md_pkg::md_result_t result
);
	localparam int W  = `MD_WIDTH;
	localparam int CW = $clog2(`MD_ITER + 1);

	md_pkg::md_unit_e        state;
	md_pkg::md_op_e          op;
	logic [`MD_TAG_BITS-1:0] tag;
	logic [W-1:0]            quotient, remainder, divisor;
	logic [CW-1:0]           count;
	logic                    neg_quotient, neg_remainder, div_zero, overflow;
	logic                    is_signed, a_neg, b_neg;
	logic [W+1:0]            shifted;
	logic [W+2:0]            divisor_x2, divisor_x3, diff1, diff2, diff3;
	logic [W-1:0]            next_quotient, next_remainder;
	logic [W-1:0]            fixed_quotient, fixed_remainder;

	assign is_signed = (req.op == md_pkg::OP_DIV) || (req.op == md_pkg::OP_REM);
	assign a_neg     = is_signed & req.a[W-1];
	assign b_neg     = is_signed & req.b[W-1];
	assign finished  = (state == md_pkg::HOLD);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One radix-4 step, two dividend bits per cycle
	assign shifted    = {remainder, quotient[W-1:W-2]};
	assign divisor_x2 = {2'b00, divisor, 1'b0};
	assign divisor_x3 = divisor_x2 + {3'b000, divisor};
	assign diff1      = {1'b0, shifted} - {3'b000, divisor};
	assign diff2      = {1'b0, shifted} - divisor_x2;
	assign diff3      = {1'b0, shifted} - divisor_x3;

	always_comb begin
		if (diff1[W+2]) begin
			next_remainder = shifted[W-1:0];
			next_quotient  = {quotient[W-3:0], 2'd0};
		end else if (diff2[W+2]) begin
			next_remainder = diff1[W-1:0];
			next_quotient  = {quotient[W-3:0], 2'd1};
		end else if (diff3[W+2]) begin
			next_remainder = diff2[W-1:0];
			next_quotient  = {quotient[W-3:0], 2'd2};
		end else begin
			next_remainder = diff3[W-1:0];
			next_quotient  = {quotient[W-3:0], 2'd3};
		end
	end

	// Sign fix-up and RV32M corner cases
	// with a zero divisor the remainder register ends up holding the dividend magnitude
	always_comb begin
		fixed_quotient  = neg_quotient ? (~quotient + 1'b1) : quotient;
		fixed_remainder = neg_remainder ? (~remainder + 1'b1) : remainder;
		if (div_zero)
			fixed_quotient = '1;
		if (overflow) begin
			fixed_quotient  = {1'b1, {(W-1){1'b0}}};
			fixed_remainder = '0;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= md_pkg::IDLE;
			count <= '0;
		end else begin
			case (state)
				md_pkg::IDLE: begin
					if (start) begin
						state <= md_pkg::RUN;
						count <= CW'(`MD_ITER);
					end
				end
				md_pkg::RUN: begin
					count <= count - 1'b1;
					if (count == CW'(1))
						state <= md_pkg::DONE;
				end
				md_pkg::DONE: state <= md_pkg::HOLD;
				md_pkg::HOLD: begin
					if (taken)
						state <= md_pkg::IDLE;
				end
				default: state <= md_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == md_pkg::IDLE && start) begin
			op            <= req.op;
			tag           <= req.tag;
			quotient      <= a_neg ? (~req.a + 1'b1) : req.a;
			divisor       <= b_neg ? (~req.b + 1'b1) : req.b;
			remainder     <= '0;
			neg_quotient  <= a_neg ^ b_neg;
			neg_remainder <= a_neg;
			div_zero      <= (req.b == '0);
			overflow      <= is_signed && (req.a == {1'b1, {(W-1){1'b0}}}) && (req.b == '1);
		end else if (state == md_pkg::RUN) begin
			quotient  <= next_quotient;
			remainder <= next_remainder;
		end else if (state == md_pkg::DONE) begin
			result.tag <= tag;
			if (op == md_pkg::OP_REM || op == md_pkg::OP_REMU)
				result.value <= fixed_remainder;
			else
				result.value <= fixed_quotient;
		end
	end

	// A result only appears a fixed latency after a start
	a_finish_after_start: assert property (@(posedge CLK) disable iff (!nRST)
		$rose(finished) |-> $past(start, `MD_ITER + 2));

endmodule

/* md_dispatch.sv */
`timescale 1ns/1ps

module md_dispatch (
	input  logic            CLK,
	input  logic            nRST,
	input  logic            issue,
	input  md_pkg::md_req_t req,
	output logic            mul_start,
	output logic            div_start,
	output md_pkg::md_req_t unit_req,
	input  logic            mul_taken,
	input  logic            div_taken,
	output logic            mul_busy,
	output logic            div_busy
);
	logic is_div;

	// Divide group is DIV, DIVU, REM, REMU
	assign is_div = req.op inside {md_pkg::OP_DIV, md_pkg::OP_DIVU,
		md_pkg::OP_REM, md_pkg::OP_REMU};

	// Issue to a busy unit is dropped
	assign mul_start = issue & ~is_div & ~mul_busy;
	assign div_start = issue & is_div & ~div_busy;

	// Both units latch the request only on their own start
	assign unit_req = req;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Busy runs from start until the arbiter takes the result
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			mul_busy <= 1'b0;
			div_busy <= 1'b0;
		end else begin
			if (mul_start)
				mul_busy <= 1'b1;
			else if (mul_taken)
				mul_busy <= 1'b0;
			if (div_start)
				div_busy <= 1'b1;
			else if (div_taken)
				div_busy <= 1'b0;
		end
	end

	a_no_issue_to_busy: assert property (@(posedge CLK) disable iff (!nRST)
		issue |-> !(is_div ? div_busy : mul_busy));

endmodule

/* md_pkg.sv */
`include "md_defs.svh"

package md_pkg;

	// RV32M funct3 order, bit 2 set for the divide group
	typedef enum logic [2:0] {
		OP_MUL    = 3'd0,
		OP_MULH   = 3'd1,
		OP_MULHSU = 3'd2,
		OP_MULHU  = 3'd3,
		OP_DIV    = 3'd4,
		OP_DIVU   = 3'd5,
		OP_REM    = 3'd6,
		OP_REMU   = 3'd7
	} md_op_e;

	// Sequencing shared by both iterative units
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		RUN  = 2'd1,
		DONE = 2'd2,
		HOLD = 2'd3
	} md_unit_e;

	typedef struct packed {
		md_op_e                  op;
		logic [`MD_TAG_BITS-1:0] tag;
		logic [`MD_WIDTH-1:0]    a;
		logic [`MD_WIDTH-1:0]    b;
	} md_req_t;

	typedef struct packed {
		logic [`MD_TAG_BITS-1:0] tag;
		logic [`MD_WIDTH-1:0]    value;
	} md_result_t;

endpackage

/* md_defs.svh */
`ifndef MD_DEFS_SVH
`define MD_DEFS_SVH

// Operand and result width of the whole coprocessor
`define MD_WIDTH 32

// Width of the tag that travels with each operation
`define MD_TAG_BITS 3

// Two bits per cycle in both radix-4 units
`define MD_ITER (`MD_WIDTH / 2)

`endif
